//--- hw/wired_lite_params.svh
`ifndef WIRED_LITE_PARAMS_SVH
`define WIRED_LITE_PARAMS_SVH

// datapath and architectural registers
`define WL_XLEN 32
`define WL_NREG 16

// immediate field of OP_ADDI
`define WL_IMM_W 16

// reorder buffer entries, power of two so the pointers wrap
`define WL_ROB_DEPTH 8

// radix-16 multiplier, four bits of the multiplier per step
`define WL_MUL_STEPS 8

`endif

//--- hw/wired_lite_pkg.sv
`include "wired_lite_params.svh"

package wired_lite_pkg;

  typedef enum logic [2:0] {
    OP_ADD  = 3'd0,
    OP_SUB  = 3'd1,
    OP_AND  = 3'd2,
    OP_XOR  = 3'd3,
    OP_ADDI = 3'd4,
    OP_MUL  = 3'd5
  } wl_op_e;

  typedef enum logic [1:0] {
    MS_IDLE = 2'd0,
    MS_BUSY = 2'd1,
    MS_DONE = 2'd2
  } wl_mul_state_e;

  typedef logic [$clog2(`WL_NREG)-1:0]      wl_areg_t;
  typedef logic [$clog2(`WL_ROB_DEPTH)-1:0] wl_tag_t;

endpackage

//--- hw/wired_lite_arf.sv
`timescale 1ns/1ps
`include "wired_lite_params.svh"

module wired_lite_arf (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic [$clog2(`WL_NREG)-1:0] raddr0_i,
  input  logic [$clog2(`WL_NREG)-1:0] raddr1_i,
  output logic [`WL_XLEN-1:0]         rdata0_o,
  output logic [`WL_XLEN-1:0]         rdata1_o,
  input  logic                        we_i,
  input  logic [$clog2(`WL_NREG)-1:0] waddr_i,
  input  logic [`WL_XLEN-1:0]         wdata_i
);

  logic [`WL_XLEN-1:0] regs_q [`WL_NREG];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < `WL_NREG; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && waddr_i != '0) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  // r0 is hardwired to zero
  assign rdata0_o = (raddr0_i == '0) ? '0 : regs_q[raddr0_i];
  assign rdata1_o = (raddr1_i == '0) ? '0 : regs_q[raddr1_i];

endmodule

//--- hw/wired_lite_rename.sv
`timescale 1ns/1ps
`include "wired_lite_params.svh"

module wired_lite_rename (
  input  logic                     clk,
  input  logic                     rst_n,
  input  wired_lite_pkg::wl_areg_t rs1_i,
  input  wired_lite_pkg::wl_areg_t rs2_i,
  output logic                     rs1_busy_o,
  output wired_lite_pkg::wl_tag_t  rs1_tag_o,
  output logic                     rs2_busy_o,
  output wired_lite_pkg::wl_tag_t  rs2_tag_o,
  input  logic                     alloc_i,
  input  wired_lite_pkg::wl_areg_t alloc_rd_i,
  input  wired_lite_pkg::wl_tag_t  alloc_tag_i,
  input  logic                     clr_i,
  input  wired_lite_pkg::wl_areg_t clr_rd_i,
  input  wired_lite_pkg::wl_tag_t  clr_tag_i
);
  import wired_lite_pkg::*;

  logic [`WL_NREG-1:0] busy_q;
  wl_tag_t             tag_q [`WL_NREG];
  logic                do_alloc;
  logic                do_clr;

  assign do_alloc = alloc_i && (alloc_rd_i != '0);

  // only the newest writer frees the mapping, and a rename of the same reg wins
  assign do_clr = clr_i && (clr_rd_i != '0) && (tag_q[clr_rd_i] == clr_tag_i)
                  && !(do_alloc && alloc_rd_i == clr_rd_i);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy_q <= '0;
    end else begin
      if (do_clr) begin
        busy_q[clr_rd_i] <= 1'b0;
      end
      if (do_alloc) begin
        busy_q[alloc_rd_i] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (do_alloc) begin
      tag_q[alloc_rd_i] <= alloc_tag_i;
    end
  end

  assign rs1_busy_o = busy_q[rs1_i];
  assign rs1_tag_o  = tag_q[rs1_i];
  assign rs2_busy_o = busy_q[rs2_i];
  assign rs2_tag_o  = tag_q[rs2_i];

endmodule

//--- hw/wired_lite_rob.sv
`timescale 1ns/1ps
`include "wired_lite_params.svh"

module wired_lite_rob (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     alloc_i,
  input  wired_lite_pkg::wl_areg_t alloc_rd_i,
  output wired_lite_pkg::wl_tag_t  tail_tag_o,
  output logic                     full_o,
  input  logic                     wr0_valid_i,
  input  wired_lite_pkg::wl_tag_t  wr0_tag_i,
  input  logic [`WL_XLEN-1:0]      wr0_data_i,
  input  logic                     wr1_valid_i,
  input  wired_lite_pkg::wl_tag_t  wr1_tag_i,
  input  logic [`WL_XLEN-1:0]      wr1_data_i,
  input  wired_lite_pkg::wl_tag_t  lk1_tag_i,
  output logic                     lk1_done_o,
  output logic [`WL_XLEN-1:0]      lk1_data_o,
  input  wired_lite_pkg::wl_tag_t  lk2_tag_i,
  output logic                     lk2_done_o,
  output logic [`WL_XLEN-1:0]      lk2_data_o,
  output logic                     retire_o,
  output wired_lite_pkg::wl_areg_t retire_rd_o,
  output wired_lite_pkg::wl_tag_t  retire_tag_o,
  output logic [`WL_XLEN-1:0]      retire_data_o
);
  import wired_lite_pkg::*;

  localparam int CNT_W = $clog2(`WL_ROB_DEPTH) + 1;

  logic [`WL_ROB_DEPTH-1:0] valid_q;
  logic [`WL_ROB_DEPTH-1:0] done_q;
  wl_areg_t                 rd_q   [`WL_ROB_DEPTH];
  logic [`WL_XLEN-1:0]      data_q [`WL_ROB_DEPTH];
  wl_tag_t                  head_q;
  wl_tag_t                  tail_q;
  logic [CNT_W-1:0]         count_q;
  logic                     do_alloc;
  logic                     do_retire;

  assign full_o     = (count_q == CNT_W'(`WL_ROB_DEPTH));
  assign tail_tag_o = tail_q;
  assign do_alloc   = alloc_i && !full_o;
  assign do_retire  = valid_q[head_q] && done_q[head_q];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q  <= '0;
      done_q   <= '0;
      head_q   <= '0;
      tail_q   <= '0;
      count_q  <= '0;
      retire_o <= 1'b0;
    end else begin
      retire_o <= do_retire;
      if (do_retire) begin
        valid_q[head_q] <= 1'b0;
        head_q          <= head_q + 1'b1;
      end
      if (do_alloc) begin
        valid_q[tail_q] <= 1'b1;
        done_q[tail_q]  <= 1'b0;
        tail_q          <= tail_q + 1'b1;
      end
      if (wr0_valid_i) begin
        done_q[wr0_tag_i] <= 1'b1;
      end
      if (wr1_valid_i) begin
        done_q[wr1_tag_i] <= 1'b1;
      end
      count_q <= count_q + CNT_W'(do_alloc) - CNT_W'(do_retire);
    end
  end

  always_ff @(posedge clk) begin
    if (do_alloc) begin
      rd_q[tail_q] <= alloc_rd_i;
    end
    if (wr0_valid_i) begin
      data_q[wr0_tag_i] <= wr0_data_i;
    end
    if (wr1_valid_i) begin
      data_q[wr1_tag_i] <= wr1_data_i;
    end
    if (do_retire) begin
      retire_rd_o   <= rd_q[head_q];
      retire_tag_o  <= head_q;
      retire_data_o <= data_q[head_q];
    end
  end

  // done and data stay put after retirement until the slot is reused,
  // which covers the cycle before the ARF write lands
  assign lk1_done_o = done_q[lk1_tag_i];
  assign lk1_data_o = data_q[lk1_tag_i];
  assign lk2_done_o = done_q[lk2_tag_i];
  assign lk2_data_o = data_q[lk2_tag_i];

endmodule

//--- hw/wired_lite_dispatch.sv
`timescale 1ns/1ps
`include "wired_lite_params.svh"

module wired_lite_dispatch (
  input  logic                     inst_valid_i,
  input  wired_lite_pkg::wl_op_e   inst_op_i,
  input  wired_lite_pkg::wl_areg_t inst_rs1_i,
  input  wired_lite_pkg::wl_areg_t inst_rs2_i,
  input  logic [`WL_IMM_W-1:0]     inst_imm_i,
  output logic                     inst_ready_o,
  input  logic                     rs1_busy_i,
  input  logic                     rs2_busy_i,
  input  logic [`WL_XLEN-1:0]      rf_rdata1_i,
  input  logic [`WL_XLEN-1:0]      rf_rdata2_i,
  input  logic                     lk1_done_i,
  input  logic [`WL_XLEN-1:0]      lk1_data_i,
  input  logic                     lk2_done_i,
  input  logic [`WL_XLEN-1:0]      lk2_data_i,
  input  logic                     rob_full_i,
  input  logic                     mul_idle_i,
  output logic                     alloc_o,
  output logic                     alu_valid_o,
  output logic                     mul_valid_o,
  output wired_lite_pkg::wl_op_e   op_o,
  output logic [`WL_XLEN-1:0]      opa_o,
  output logic [`WL_XLEN-1:0]      opb_o
);
  import wired_lite_pkg::*;

  logic is_mul;
  logic is_addi;
  logic src1_ok;
  logic src2_ok;
  logic fire;

  assign is_mul  = (inst_op_i == OP_MUL);
  assign is_addi = (inst_op_i == OP_ADDI);

  // r0 and the unused rs2 of addi never hold dispatch
  assign src1_ok = (inst_rs1_i == '0) || !rs1_busy_i || lk1_done_i;
  assign src2_ok = is_addi || (inst_rs2_i == '0) || !rs2_busy_i || lk2_done_i;

  assign inst_ready_o = !rob_full_i && src1_ok && src2_ok && (!is_mul || mul_idle_i);
  assign fire         = inst_valid_i && inst_ready_o;

  assign alloc_o     = fire;
  assign alu_valid_o = fire && !is_mul;
  assign mul_valid_o = fire && is_mul;
  assign op_o        = inst_op_i;

  // pending source comes from its completed rob entry
  assign opa_o = rs1_busy_i ? lk1_data_i : rf_rdata1_i;
  assign opb_o = is_addi    ? {{(`WL_XLEN - `WL_IMM_W){inst_imm_i[`WL_IMM_W-1]}}, inst_imm_i}
               : rs2_busy_i ? lk2_data_i : rf_rdata2_i;

endmodule

//--- hw/wired_lite_alu.sv
`timescale 1ns/1ps
`include "wired_lite_params.svh"

module wired_lite_alu (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    valid_i,
  input  wired_lite_pkg::wl_op_e  op_i,
  input  wired_lite_pkg::wl_tag_t tag_i,
  input  logic [`WL_XLEN-1:0]     opa_i,
  input  logic [`WL_XLEN-1:0]     opb_i,
  output logic                    res_valid_o,
  output wired_lite_pkg::wl_tag_t res_tag_o,
  output logic [`WL_XLEN-1:0]     res_data_o
);
  import wired_lite_pkg::*;

  logic [`WL_XLEN-1:0] result;

  always_comb begin
    case (op_i)
      OP_SUB:  result = opa_i - opb_i;
      OP_AND:  result = opa_i & opb_i;
      OP_XOR:  result = opa_i ^ opb_i;
      // add and addi, imm already in opb
      default: result = opa_i + opb_i;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      res_valid_o <= 1'b0;
    end else begin
      res_valid_o <= valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (valid_i) begin
      res_tag_o  <= tag_i;
      res_data_o <= result;
    end
  end

endmodule

//--- hw/wired_lite_muler.sv
`timescale 1ns/1ps
`include "wired_lite_params.svh"

module wired_lite_muler (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    valid_i,
  input  wired_lite_pkg::wl_tag_t tag_i,
  input  logic [`WL_XLEN-1:0]     opa_i,
  input  logic [`WL_XLEN-1:0]     opb_i,
  output logic                    idle_o,
  output logic                    res_valid_o,
  output wired_lite_pkg::wl_tag_t res_tag_o,
  output logic [`WL_XLEN-1:0]     res_data_o
);
  import wired_lite_pkg::*;

  localparam int                   STEP_W     = $clog2(`WL_MUL_STEPS);
  localparam int                   RADIX_BITS = `WL_XLEN / `WL_MUL_STEPS;
  localparam logic [STEP_W-1:0]    STEP_LAST  = STEP_W'(`WL_MUL_STEPS - 1);

  wl_mul_state_e       state_q;
  logic [STEP_W-1:0]   step_q;
  wl_tag_t             tag_q;
  logic [`WL_XLEN-1:0] mcand_q;
  logic [`WL_XLEN-1:0] mplier_q;
  logic [`WL_XLEN-1:0] acc_q;
  logic [`WL_XLEN-1:0] step_sum;

  // one partial product per multiplier bit in this digit
  always_comb begin
    step_sum = '0;
    for (int i = 0; i < RADIX_BITS; i++) begin
      if (mplier_q[i]) begin
        step_sum = step_sum + (mcand_q << i);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= MS_IDLE;
      step_q  <= '0;
    end else begin
      case (state_q)
        MS_IDLE: begin
          step_q <= '0;
          if (valid_i) begin
            state_q <= MS_BUSY;
          end
        end
        MS_BUSY: begin
          step_q <= step_q + 1'b1;
          if (step_q == STEP_LAST) begin
            state_q <= MS_DONE;
          end
        end
        default: state_q <= MS_IDLE;
      endcase
    end
  end

  // only the low word of the product is kept
  always_ff @(posedge clk) begin
    if (state_q == MS_IDLE && valid_i) begin
      tag_q    <= tag_i;
      mcand_q  <= opa_i;
      mplier_q <= opb_i;
      acc_q    <= '0;
    end else if (state_q == MS_BUSY) begin
      acc_q    <= acc_q + step_sum;
      mcand_q  <= mcand_q << RADIX_BITS;
      mplier_q <= mplier_q >> RADIX_BITS;
    end
  end

  assign idle_o      = (state_q == MS_IDLE);
  assign res_valid_o = (state_q == MS_DONE);
  assign res_tag_o   = tag_q;
  assign res_data_o  = acc_q;

endmodule

//--- hw/wired_lite_backend.sv
`timescale 1ns/1ps
`include "wired_lite_params.svh"

module wired_lite_backend (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     inst_valid_i,
  input  wired_lite_pkg::wl_op_e   inst_op_i,
  input  wired_lite_pkg::wl_areg_t inst_rd_i,
  input  wired_lite_pkg::wl_areg_t inst_rs1_i,
  input  wired_lite_pkg::wl_areg_t inst_rs2_i,
  input  logic [`WL_IMM_W-1:0]     inst_imm_i,
  output logic                     inst_ready_o,
  output logic                     commit_valid_o,
  output wired_lite_pkg::wl_areg_t commit_rd_o,
  output logic [`WL_XLEN-1:0]      commit_data_o
);
  import wired_lite_pkg::*;

  // operand path
  logic                rs1_busy;
  logic                rs2_busy;
  wl_tag_t             rs1_tag;
  wl_tag_t             rs2_tag;
  logic [`WL_XLEN-1:0] rf_rdata1;
  logic [`WL_XLEN-1:0] rf_rdata2;
  logic                lk1_done;
  logic                lk2_done;
  logic [`WL_XLEN-1:0] lk1_data;
  logic [`WL_XLEN-1:0] lk2_data;

  // allocation and issue
  wl_tag_t             tail_tag;
  logic                rob_full;
  logic                alloc;
  logic                alu_valid;
  logic                mul_valid;
  logic                mul_idle;
  wl_op_e              op;
  logic [`WL_XLEN-1:0] opa;
  logic [`WL_XLEN-1:0] opb;

  // completion and retirement
  logic                alu_res_valid;
  wl_tag_t             alu_res_tag;
  logic [`WL_XLEN-1:0] alu_res_data;
  logic                mul_res_valid;
  wl_tag_t             mul_res_tag;
  logic [`WL_XLEN-1:0] mul_res_data;
  wl_tag_t             retire_tag;

  wired_lite_arf i_arf (
    .clk(clk), .rst_n(rst_n),
    .raddr0_i(inst_rs1_i), .rdata0_o(rf_rdata1),
    .raddr1_i(inst_rs2_i), .rdata1_o(rf_rdata2),
    .we_i(commit_valid_o), .waddr_i(commit_rd_o), .wdata_i(commit_data_o)
  );

  wired_lite_rename i_rename (
    .clk(clk), .rst_n(rst_n),
    .rs1_i(inst_rs1_i), .rs1_busy_o(rs1_busy), .rs1_tag_o(rs1_tag),
    .rs2_i(inst_rs2_i), .rs2_busy_o(rs2_busy), .rs2_tag_o(rs2_tag),
    .alloc_i(alloc), .alloc_rd_i(inst_rd_i), .alloc_tag_i(tail_tag),
    .clr_i(commit_valid_o), .clr_rd_i(commit_rd_o), .clr_tag_i(retire_tag)
  );

  wired_lite_rob i_rob (
    .clk(clk), .rst_n(rst_n),
    .alloc_i(alloc), .alloc_rd_i(inst_rd_i), .tail_tag_o(tail_tag), .full_o(rob_full),
    .wr0_valid_i(alu_res_valid), .wr0_tag_i(alu_res_tag), .wr0_data_i(alu_res_data),
    .wr1_valid_i(mul_res_valid), .wr1_tag_i(mul_res_tag), .wr1_data_i(mul_res_data),
    .lk1_tag_i(rs1_tag), .lk1_done_o(lk1_done), .lk1_data_o(lk1_data),
    .lk2_tag_i(rs2_tag), .lk2_done_o(lk2_done), .lk2_data_o(lk2_data),
    .retire_o(commit_valid_o), .retire_rd_o(commit_rd_o),
    .retire_tag_o(retire_tag), .retire_data_o(commit_data_o)
  );

  wired_lite_dispatch i_dispatch (
    .inst_valid_i(inst_valid_i), .inst_op_i(inst_op_i),
    .inst_rs1_i(inst_rs1_i), .inst_rs2_i(inst_rs2_i), .inst_imm_i(inst_imm_i),
    .inst_ready_o(inst_ready_o),
    .rs1_busy_i(rs1_busy), .rs2_busy_i(rs2_busy),
    .rf_rdata1_i(rf_rdata1), .rf_rdata2_i(rf_rdata2),
    .lk1_done_i(lk1_done), .lk1_data_i(lk1_data),
    .lk2_done_i(lk2_done), .lk2_data_i(lk2_data),
    .rob_full_i(rob_full), .mul_idle_i(mul_idle),
    .alloc_o(alloc), .alu_valid_o(alu_valid), .mul_valid_o(mul_valid),
    .op_o(op), .opa_o(opa), .opb_o(opb)
  );

  wired_lite_alu i_alu (
    .clk(clk), .rst_n(rst_n),
    .valid_i(alu_valid), .op_i(op), .tag_i(tail_tag), .opa_i(opa), .opb_i(opb),
    .res_valid_o(alu_res_valid), .res_tag_o(alu_res_tag), .res_data_o(alu_res_data)
  );

  wired_lite_muler i_muler (
    .clk(clk), .rst_n(rst_n),
    .valid_i(mul_valid), .tag_i(tail_tag), .opa_i(opa), .opb_i(opb), .idle_o(mul_idle),
    .res_valid_o(mul_res_valid), .res_tag_o(mul_res_tag), .res_data_o(mul_res_data)
  );

endmodule

//--- test/wired_lite_props.sv
`timescale 1ns/1ps
`include "wired_lite_params.svh"

module wired_lite_props (
  input logic                           clk,
  input logic                           rst_n,
  input logic                           alloc_i,
  input logic                           full_i,
  input logic                           retire_i,
  input logic [$clog2(`WL_ROB_DEPTH):0] count_i
);

  // a retire pulse drains an entry that was there the cycle before
  retire_not_empty: assert property (
    @(posedge clk) disable iff (!rst_n)
    retire_i |-> ($past(count_i) != '0)
  ) else $error("retire pulse while the rob held no entry");

  no_alloc_when_full: assert property (
    @(posedge clk) disable iff (!rst_n)
    alloc_i |-> !full_i
  ) else $error("allocation while the rob is full");

  // first edge out of reset
  quiet_after_reset: assert property (
    @(posedge clk)
    $rose(rst_n) |-> !retire_i
  ) else $error("retire pulse in the first cycle after reset");

endmodule

//--- test/wired_lite_tb.sv
`timescale 1ns/1ps
`include "wired_lite_params.svh"

module wired_lite_tb;
  import wired_lite_pkg::*;

  localparam int N_DIRECTED = 8;
  localparam int N_RANDOM   = 400;
  localparam int MAX_CYCLES = (N_DIRECTED + N_RANDOM) * (`WL_MUL_STEPS + 4) + 100;

  logic                 clk;
  logic                 rst_n;
  logic                 inst_valid;
  wl_op_e               inst_op;
  wl_areg_t             inst_rd;
  wl_areg_t             inst_rs1;
  wl_areg_t             inst_rs2;
  logic [`WL_IMM_W-1:0] inst_imm;
  logic                 inst_ready;
  logic                 commit_valid;
  wl_areg_t             commit_rd;
  logic [`WL_XLEN-1:0]  commit_data;

  // reference register file, updated in program order at acceptance
  logic [`WL_XLEN-1:0]  model_regs [`WL_NREG];
  wl_areg_t             exp_rd_q [$];
  logic [`WL_XLEN-1:0]  exp_data_q [$];
  int                   accepted = 0;
  int                   committed = 0;
  int                   cycles = 0;

  wired_lite_backend i_wired_lite_backend (
    .clk(clk), .rst_n(rst_n),
    .inst_valid_i(inst_valid), .inst_op_i(inst_op), .inst_rd_i(inst_rd),
    .inst_rs1_i(inst_rs1), .inst_rs2_i(inst_rs2), .inst_imm_i(inst_imm),
    .inst_ready_o(inst_ready),
    .commit_valid_o(commit_valid), .commit_rd_o(commit_rd), .commit_data_o(commit_data)
  );

  bind wired_lite_rob wired_lite_props i_props (
    .clk(clk), .rst_n(rst_n), .alloc_i(alloc_i), .full_i(full_o),
    .retire_i(retire_o), .count_i(count_q)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic [`WL_XLEN-1:0] model_exec(input wl_op_e op,
      input logic [`WL_XLEN-1:0] a, input logic [`WL_XLEN-1:0] b,
      input logic [`WL_IMM_W-1:0] imm);
    logic signed [`WL_XLEN-1:0] imm_ext;
    imm_ext = $signed(imm);
    case (op)
      OP_ADD:  return a + b;
      OP_SUB:  return a - b;
      OP_AND:  return a & b;
      OP_XOR:  return a ^ b;
      OP_ADDI: return a + imm_ext;
      default: return a * b;
    endcase
  endfunction

  // present one instruction and hold it until the handshake completes
  task automatic send(input wl_op_e op, input wl_areg_t rd, input wl_areg_t rs1,
                      input wl_areg_t rs2, input logic [`WL_IMM_W-1:0] imm);
    logic [`WL_XLEN-1:0] result;
    @(negedge clk);
    inst_valid = 1'b1;
    inst_op    = op;
    inst_rd    = rd;
    inst_rs1   = rs1;
    inst_rs2   = rs2;
    inst_imm   = imm;
    // ready has settled halfway through the low phase
    #2;
    while (!inst_ready) begin
      @(negedge clk);
      #2;
    end
    @(posedge clk);
    result = model_exec(op, model_regs[rs1], model_regs[rs2], imm);
    exp_rd_q.push_back(rd);
    exp_data_q.push_back(result);
    if (rd != '0) begin
      model_regs[rd] = result;
    end
    accepted++;
    assert (accepted - committed <= `WL_ROB_DEPTH) else begin
      $display("error at %0t: %0d instructions in flight, more than the rob holds",
               $time, accepted - committed);
      $display("Something failed");
      $fatal(1);
    end
  endtask

  // commit pulses are stable at the falling edge
  always @(negedge clk) begin
    if (rst_n && commit_valid) begin
      assert (exp_rd_q.size() > 0) else begin
        $display("error at %0t: commit_valid_o pulsed with nothing outstanding", $time);
        $display("Something failed");
        $fatal(1);
      end
      assert (commit_rd == exp_rd_q[0]) else begin
        $display("error at %0t: commit_rd_o = %0d, expected %0d",
                 $time, commit_rd, exp_rd_q[0]);
        $display("Something failed");
        $fatal(1);
      end
      assert (commit_data == exp_data_q[0]) else begin
        $display("error at %0t: commit_data_o = %h, expected %h",
                 $time, commit_data, exp_data_q[0]);
        $display("Something failed");
        $fatal(1);
      end
      void'(exp_rd_q.pop_front());
      void'(exp_data_q.pop_front());
      committed++;
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout after %0d cycles with %0d instructions not committed",
               cycles, exp_rd_q.size());
      $display("Something failed");
      $fatal(1);
    end
  end

  initial begin
    int       pick;
    wl_op_e   op;
    wl_areg_t rd;
    wl_areg_t rs1;
    wl_areg_t rs2;
    rst_n      = 1'b0;
    inst_valid = 1'b0;
    inst_op    = OP_ADD;
    inst_rd    = '0;
    inst_rs1   = '0;
    inst_rs2   = '0;
    inst_imm   = '0;
    for (int i = 0; i < `WL_NREG; i++) begin
      model_regs[i] = '0;
    end
    void'($urandom(32'had1d_be44));
    repeat (5) @(negedge clk);
    rst_n = 1'b1;

    // idle, an add is shown but not valid
    repeat (4) begin
      @(negedge clk);
      assert (inst_ready && !commit_valid) else begin
        $display("error at %0t: inst_ready_o = %b, commit_valid_o = %b, expected 1 and 0",
                 $time, inst_ready, commit_valid);
        $display("Something failed");
        $fatal(1);
      end
    end

    send(OP_ADDI, 4'd1, 4'd0, 4'd0, 16'h1234);
    send(OP_ADDI, 4'd2, 4'd0, 4'd0, 16'hff9c);
    // long mul, then independent alu ops that finish first
    send(OP_MUL,  4'd3, 4'd1, 4'd2, 16'h0000);
    send(OP_ADD,  4'd4, 4'd1, 4'd1, 16'h0000);
    send(OP_XOR,  4'd5, 4'd2, 4'd1, 16'h0000);
    send(OP_SUB,  4'd6, 4'd4, 4'd5, 16'h0000);
    // write to r0 is dropped, then r0 and the mul result are read
    send(OP_ADDI, 4'd0, 4'd1, 4'd0, 16'h0007);
    send(OP_AND,  4'd7, 4'd0, 4'd3, 16'h0000);

    // small register range keeps dependencies frequent
    for (int n = 0; n < N_RANDOM; n++) begin
      pick = $urandom_range(99);
      if (pick < 30) begin
        op = OP_MUL;
      end else begin
        op = wl_op_e'($urandom_range(4));
      end
      rd  = wl_areg_t'($urandom_range(5));
      rs1 = wl_areg_t'($urandom_range(5));
      rs2 = wl_areg_t'($urandom_range(5));
      send(op, rd, rs1, rs2, 16'($urandom));
    end

    @(negedge clk);
    inst_valid = 1'b0;
    while (exp_rd_q.size() != 0) begin
      @(negedge clk);
    end
    // a stray extra commit would still trip the checker here
    repeat (4) @(negedge clk);

    $display("Everything OK");
    $finish;
  end

endmodule

//--- list.f
+incdir+hw
hw/wired_lite_pkg.sv
hw/wired_lite_arf.sv
hw/wired_lite_rename.sv
hw/wired_lite_rob.sv
hw/wired_lite_dispatch.sv
hw/wired_lite_alu.sv
hw/wired_lite_muler.sv
hw/wired_lite_backend.sv
test/wired_lite_props.sv
test/wired_lite_tb.sv

//--- Bender.yml
package:
  name: wired_lite

sources:
  - include_dirs:
      - hw
    files:
      - hw/wired_lite_pkg.sv
      - hw/wired_lite_arf.sv
      - hw/wired_lite_rename.sv
      - hw/wired_lite_rob.sv
      - hw/wired_lite_dispatch.sv
      - hw/wired_lite_alu.sv
      - hw/wired_lite_muler.sv
      - hw/wired_lite_backend.sv
  - target: test
    include_dirs:
      - hw
    files:
      - test/wired_lite_props.sv
      - test/wired_lite_tb.sv
